// File: mc_defs.svh
`ifndef MC_DEFS_SVH
`define MC_DEFS_SVH

// array size and sample format
`define MC_NUM_CORES 8
`define MC_DATA_W 32

// each core emits one sum per MC_BLOCK_LEN accepted samples
`define MC_BLOCK_LEN 4

// cycles between the release of one core and the next
`define MC_STAGGER 16

// counter and index widths, sized for the values above
`define MC_CORE_ID_W 3
`define MC_BLOCK_CNT_W 3
`define MC_STAGGER_W 5
`define MC_COLL_W 16

`endif

// File: mc_pkg.sv
`include "mc_defs.svh"

package mc_pkg;

	// one broadcast input sample
	typedef logic signed [`MC_DATA_W-1:0] sample_t;

	// block sum, wraps modulo 2**MC_DATA_W
	typedef logic signed [`MC_DATA_W-1:0] sum_t;

	typedef logic [`MC_CORE_ID_W-1:0] core_id_t;
	typedef logic [`MC_BLOCK_CNT_W-1:0] block_cnt_t;
	typedef logic [`MC_STAGGER_W-1:0] stagger_cnt_t;
	typedef logic [`MC_COLL_W-1:0] coll_cnt_t;

	typedef enum logic [0:0] {
		SEQ_RELEASE,
		SEQ_DONE
	} seq_state_e;

endpackage

// File: reset_sequencer.sv
`timescale 1ns/1ps

`include "mc_defs.svh"

module reset_sequencer (
	input  logic                     clk,
	input  logic                     arst_n,
	output logic [`MC_NUM_CORES-1:0] core_run,
	output logic                     all_running
);

	// index of the last core and last cycle of one stagger slot
	localparam mc_pkg::core_id_t last_idx = mc_pkg::core_id_t'(`MC_NUM_CORES - 1);
	localparam mc_pkg::stagger_cnt_t stagger_last = mc_pkg::stagger_cnt_t'(`MC_STAGGER - 1);

	mc_pkg::seq_state_e state;
	mc_pkg::core_id_t core_idx;
	mc_pkg::stagger_cnt_t stagger_cnt;

	logic release_now;
	logic last_core;
	logic slot_end;

	// a core is released in the first cycle of its slot
	assign release_now = (state == mc_pkg::SEQ_RELEASE) && (stagger_cnt == '0);
	assign last_core = (core_idx == last_idx);
	assign slot_end = (stagger_cnt == stagger_last);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= mc_pkg::SEQ_RELEASE;
			core_idx <= '0;
			stagger_cnt <= '0;
		end else begin
			case (state)
				mc_pkg::SEQ_RELEASE: begin
					if (release_now && last_core) begin
						state <= mc_pkg::SEQ_DONE; // nothing left to release
					end else if (slot_end) begin
						stagger_cnt <= '0;
						core_idx <= core_idx + 1'b1;
					end else begin
						stagger_cnt <= stagger_cnt + 1'b1;
					end
				end
				mc_pkg::SEQ_DONE: begin
					state <= mc_pkg::SEQ_DONE;
				end
				default: begin
					state <= mc_pkg::SEQ_RELEASE;
				end
			endcase
		end
	end

	// run bits only ever rise, a core stays released until the next reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			core_run <= '0;
		end else if (release_now) begin
			core_run[core_idx] <= 1'b1;
		end
	end

	// registered from the state, so it rises one edge after the last release
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			all_running <= 1'b0;
		end else if (state == mc_pkg::SEQ_DONE) begin
			all_running <= 1'b1;
		end
	end

endmodule

// File: stream_core.sv
`timescale 1ns/1ps

`include "mc_defs.svh"

module stream_core (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            run,
	input  logic            in_valid,
	input  mc_pkg::sample_t in_data,
	output logic            out_valid,
	output mc_pkg::sum_t    out_sum
);

	// counter value when the block's last sample arrives
	localparam mc_pkg::block_cnt_t block_last = mc_pkg::block_cnt_t'(`MC_BLOCK_LEN - 1);

	mc_pkg::sum_t acc;
	mc_pkg::block_cnt_t sample_cnt;

	logic accept;
	logic block_end;
	mc_pkg::sum_t sum_next;

	// every running core takes every broadcast sample
	assign accept = run && in_valid;
	assign block_end = accept && (sample_cnt == block_last);

	// the sum wraps at the data width
	assign sum_next = acc + in_data;

	// accumulator and sample counter move only on accepted samples
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			acc <= '0;
			sample_cnt <= '0;
		end else if (block_end) begin
			acc <= '0;
			sample_cnt <= '0;
		end else if (accept) begin
			acc <= sum_next;
			sample_cnt <= sample_cnt + 1'b1;
		end
	end

	// the strobe lasts exactly one cycle per completed block
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= block_end;
		end
	end

	// the sum includes the sample taken on the closing edge
	always_ff @(posedge clk) begin
		if (block_end) begin
			out_sum <= sum_next;
		end
	end

endmodule

// File: result_merger.sv
`timescale 1ns/1ps

`include "mc_defs.svh"

module result_merger (
	input  logic                                   clk,
	input  logic                                   arst_n,
	input  logic             [`MC_NUM_CORES-1:0]   core_valid,
	input  mc_pkg::sum_t     [`MC_NUM_CORES-1:0]   core_sum,
	output logic                                   result_valid,
	output mc_pkg::sum_t                           result_sum,
	output mc_pkg::core_id_t                       result_core,
	output mc_pkg::coll_cnt_t                      collision_count
);

	logic sel_valid;
	mc_pkg::core_id_t sel_idx;
	logic collision;

	// scan from the top so the lowest valid index is the one left standing
	always_comb begin
		sel_valid = 1'b0;
		sel_idx = '0;
		for (int i = `MC_NUM_CORES - 1; i >= 0; i--) begin
			if (core_valid[i]) begin
				sel_valid = 1'b1;
				sel_idx = mc_pkg::core_id_t'(i);
			end
		end
	end

	// more than one bit set when clearing the lowest set bit leaves something
	assign collision = (core_valid & (core_valid - 1'b1)) != '0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= sel_valid;
		end
	end

	// losing cores are simply dropped
	always_ff @(posedge clk) begin
		if (sel_valid) begin
			result_sum <= core_sum[sel_idx];
			result_core <= sel_idx;
		end
	end

	// saturates rather than wrapping
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			collision_count <= '0;
		end else if (collision && (collision_count != '1)) begin
			collision_count <= collision_count + 1'b1;
		end
	end

endmodule

// File: multicore_top.sv
`timescale 1ns/1ps

`include "mc_defs.svh"

module multicore_top (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              in_valid,
	input  mc_pkg::sample_t   in_data,
	output logic              result_valid,
	output mc_pkg::sum_t      result_sum,
	output mc_pkg::core_id_t  result_core,
	output mc_pkg::coll_cnt_t collision_count,
	output logic              all_running
);

	logic [`MC_NUM_CORES-1:0] core_run;
	logic [`MC_NUM_CORES-1:0] core_valid;
	mc_pkg::sum_t [`MC_NUM_CORES-1:0] core_sum; // one slice per core

	reset_sequencer seq0 (
		.clk         (clk),
		.arst_n      (arst_n),
		.core_run    (core_run),
		.all_running (all_running)
	);

	// the input bus is broadcast unchanged to all cores
	for (genvar k = 0; k < `MC_NUM_CORES; k++) begin : core_g
		stream_core core0 (
			.clk       (clk),
			.arst_n    (arst_n),
			.run       (core_run[k]),
			.in_valid  (in_valid),
			.in_data   (in_data),
			.out_valid (core_valid[k]),
			.out_sum   (core_sum[k])
		);
	end

	result_merger merge0 (
		.clk             (clk),
		.arst_n          (arst_n),
		.core_valid      (core_valid),
		.core_sum        (core_sum),
		.result_valid    (result_valid),
		.result_sum      (result_sum),
		.result_core     (result_core),
		.collision_count (collision_count)
	);

endmodule

// File: multicore_assert.sv
`timescale 1ns/1ps

`include "mc_defs.svh"

module multicore_assert (
	input logic              clk,
	input logic              arst_n,
	input logic              result_valid,
	input mc_pkg::core_id_t  result_core,
	input mc_pkg::coll_cnt_t collision_count,
	input logic              all_running
);

	// a forwarded result always names one of the cores
	result_core_in_range: assert property (
		@(posedge clk) disable iff (!arst_n)
		result_valid |-> (!$isunknown(result_core) && (result_core < `MC_NUM_CORES))
	) else $error("result_core is not a valid core index while result_valid is high");

	collision_count_monotonic: assert property (
		@(posedge clk) disable iff (!arst_n)
		collision_count >= $past(collision_count) // saturates, never wraps
	) else $error("collision_count decreased without a reset");

	// once every core is released the flag holds until the next reset
	all_running_sticky: assert property (
		@(posedge clk) disable iff (!arst_n)
		$past(all_running) |-> all_running
	) else $error("all_running fell without a reset");

endmodule

// File: multicore_tb.sv
`timescale 1ns/1ps

`include "mc_defs.svh"

module multicore_tb;

	localparam int CLK_HALF = 50;
	localparam int RUN1_CYCLES = 400;
	localparam int RUN2_CYCLES = 300;
	localparam int RESET_CYCLES = 2;
	localparam int RELEASE_CYCLES = (`MC_NUM_CORES - 1) * `MC_STAGGER + 2;
	localparam int MARGIN_CYCLES = 100;
	localparam int WATCHDOG_CYCLES = RUN1_CYCLES + RUN2_CYCLES + 2 * RESET_CYCLES
		+ RELEASE_CYCLES + MARGIN_CYCLES;

	logic clk;
	logic arst_n;
	logic in_valid;
	mc_pkg::sample_t in_data;
	logic result_valid;
	mc_pkg::sum_t result_sum;
	mc_pkg::core_id_t result_core;
	mc_pkg::coll_cnt_t collision_count;
	logic all_running;

	// reference model state, edge_no counts edges since reset was released
	int edge_no;
	mc_pkg::sum_t acc_m [`MC_NUM_CORES];
	int cnt_m [`MC_NUM_CORES];
	logic [`MC_NUM_CORES-1:0] valid_m;
	mc_pkg::sum_t sum_m [`MC_NUM_CORES];
	logic res_valid_m;
	mc_pkg::sum_t res_sum_m;
	mc_pkg::core_id_t res_core_m;
	mc_pkg::coll_cnt_t coll_m;
	int core0_taken;

	int errors;
	int checks;
	int collisions_seen;
	logic [31:0] rng;

	multicore_top dut0 (
		.clk             (clk),
		.arst_n          (arst_n),
		.in_valid        (in_valid),
		.in_data         (in_data),
		.result_valid    (result_valid),
		.result_sum      (result_sum),
		.result_core     (result_core),
		.collision_count (collision_count),
		.all_running     (all_running)
	);

	bind multicore_top multicore_assert assert0 (
		.clk             (clk),
		.arst_n          (arst_n),
		.result_valid    (result_valid),
		.result_core     (result_core),
		.collision_count (collision_count),
		.all_running     (all_running)
	);

	always #(CLK_HALF) clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// core k gets its run bit on this edge and accepts from the next one on
	function automatic int release_edge(input int k);
		return 1 + k * `MC_STAGGER;
	endfunction

	task automatic clear_model;
		edge_no = 0;
		for (int k = 0; k < `MC_NUM_CORES; k++) begin
			acc_m[k] = '0;
			cnt_m[k] = 0;
			sum_m[k] = '0;
		end
		valid_m = '0;
		res_valid_m = 1'b0;
		res_sum_m = '0;
		res_core_m = '0;
		coll_m = '0;
		core0_taken = 0;
	endtask

	// advance the model by one rising edge, inputs still hold their pre-edge values
	task automatic model_edge;
		logic [`MC_NUM_CORES-1:0] next_valid;
		int winner;
		int nvalid;
		edge_no++;
		winner = -1;
		nvalid = 0;
		for (int k = 0; k < `MC_NUM_CORES; k++) begin
			if (valid_m[k]) begin
				nvalid++;
				if (winner < 0)
					winner = k; // lowest index wins
			end
		end
		res_valid_m = (nvalid > 0);
		if (winner >= 0) begin
			res_sum_m = sum_m[winner];
			res_core_m = mc_pkg::core_id_t'(winner);
		end
		if (nvalid > 1) begin
			collisions_seen++;
			if (coll_m != '1)
				coll_m = coll_m + 1'b1;
		end
		next_valid = '0;
		for (int k = 0; k < `MC_NUM_CORES; k++) begin
			if (in_valid && (edge_no > release_edge(k))) begin
				acc_m[k] = acc_m[k] + in_data;
				cnt_m[k]++;
				if (k == 0)
					core0_taken++;
				if (cnt_m[k] == `MC_BLOCK_LEN) begin
					next_valid[k] = 1'b1;
					sum_m[k] = acc_m[k];
					acc_m[k] = '0;
					cnt_m[k] = 0;
				end
			end
		end
		valid_m = next_valid;
	endtask

	task automatic check_equal(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic check_outputs;
		check_equal("result_valid", result_valid, res_valid_m);
		if (res_valid_m) begin
			check_equal("result_sum", result_sum, res_sum_m);
			check_equal("result_core", result_core, res_core_m);
		end
		check_equal("collision_count", collision_count, coll_m);
		check_equal("all_running", all_running,
			edge_no > release_edge(`MC_NUM_CORES - 1));
		checks++;
		assert (!(result_valid && (core0_taken < `MC_BLOCK_LEN))) else begin
			errors++;
			$display("Error at %0d ns: result before core 0 finished its first block", $time);
		end
	endtask

	task automatic check_reset_outputs;
		check_equal("result_valid in reset", result_valid, 1'b0);
		check_equal("all_running in reset", all_running, 1'b0);
		check_equal("collision_count in reset", collision_count, '0);
	endtask

	task automatic drive_random;
		rng = xorshift32(rng);
		in_valid = rng[16]; // about one cycle in two carries a sample
		rng = xorshift32(rng);
		in_data = mc_pkg::sample_t'(rng);
	endtask

	// called 5 ns after an edge, or 5 ns into the run
	task automatic apply_reset;
		arst_n = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		#1;
		check_reset_outputs;
		repeat (RESET_CYCLES) @(posedge clk);
		#5;
		check_reset_outputs;
		arst_n = 1'b1;
		clear_model;
	endtask

	task automatic run_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			model_edge;
			#5;
			check_outputs;
			drive_random;
		end
	endtask

	initial begin
		errors = 0;
		checks = 0;
		collisions_seen = 0;
		rng = 32'hd992_dbbb;
		clk = 1'b0;
		arst_n = 1'b1;
		in_valid = 1'b0;
		in_data = '0;
		clear_model;
		#5;
		apply_reset;
		run_cycles(RUN1_CYCLES);
		apply_reset; // mid-run, every core is busy here
		run_cycles(RUN2_CYCLES);
		checks++;
		assert (collisions_seen > 0) else begin
			errors++;
			$display("no cycle with two or more core results was seen, collisions went untested");
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * 2 * CLK_HALF);
		$display("timeout: the test did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("** FAIL **");
		$finish;
	end

endmodule

// File: project.f
+incdir+.
mc_pkg.sv
reset_sequencer.sv
stream_core.sv
result_merger.sv
multicore_top.sv
multicore_assert.sv
multicore_tb.sv
